// File: source/riscv_isa_pkg.sv
package riscv_isa_pkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_system = 7'b1110011
    } opcode_t;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_t    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_t    opcode;
    } s_fmt_t;

    // Branch offset bits are scattered over the word
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_t    opcode;
    } b_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
    } instr_u;

endpackage

// File: source/core_ctrl_pkg.sv
package core_ctrl_pkg;

    // Register and data bus width
    localparam int unsigned xlen = 64;

    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_xor = 4'd4,
        alu_slt = 4'd5
    } alu_cmd_t;

    // One instruction walks through these states in turn
    typedef enum logic [2:0] {
        st_fetch     = 3'd0,
        st_decode    = 3'd1,
        st_execute   = 3'd2,
        st_mem       = 3'd3,
        st_writeback = 3'd4,
        st_halt      = 3'd5
    } ctrl_state_t;

endpackage

// File: source/mem_req_if.sv
`timescale 1ns/1ps

interface mem_req_if
    import core_ctrl_pkg::*;
#(
    parameter int addr_bits = 16
) ();

    logic                 req;
    logic                 we;
    logic [addr_bits-1:0] addr;
    logic [xlen-1:0]      wdata;
    logic [xlen-1:0]      rdata;
    logic                 done;

    // Request side of the core
    modport core (output req, we, addr, wdata, input rdata, done);

    modport bus (input req, we, addr, wdata, output rdata, done);

endinterface

// File: source/alu.sv
`timescale 1ns/1ps

module alu
    import core_ctrl_pkg::*;
(
    input  logic [xlen-1:0] i_a,
    input  logic [xlen-1:0] i_b,
    input  alu_cmd_t        i_cmd,
    output logic [xlen-1:0] o_res,
    output logic            o_zero
);

    logic less;

    // Signed compare for SLT
    assign less = $signed(i_a) < $signed(i_b);

    always_comb begin
        case (i_cmd)
            alu_add: o_res = i_a + i_b;
            alu_sub: o_res = i_a - i_b;
            alu_and: o_res = i_a & i_b;
            alu_or:  o_res = i_a | i_b;
            alu_xor: o_res = i_a ^ i_b;
            alu_slt: o_res = {{(xlen-1){1'b0}}, less};
            default: o_res = '0;
        endcase
    end

    // Branches compare by subtraction
    assign o_zero = (o_res == '0);

endmodule

// File: source/fetch_decode.sv
`timescale 1ns/1ps

module fetch_decode
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;
(
    input  logic            clk,
    input  logic            i_rst,
    input  logic            i_fetch_done,
    input  logic [xlen-1:0] i_rdata,
    input  logic            i_pc_word_half,
    output instr_u          o_instr,
    output logic [xlen-1:0] o_imm
);

    logic [31:0] fetched;

    // Bit 2 of pc picks the half of the doubleword that holds the instruction
    assign fetched = i_pc_word_half ? i_rdata[xlen-1:32] : i_rdata[31:0];

    // Instruction register
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_instr <= '0;
        end else if (i_fetch_done) begin
            o_instr <= fetched;
        end
    end

    // Immediate format follows the opcode
    always_comb begin
        case (o_instr.r.opcode)
            opc_op_imm, opc_load: begin
                o_imm = {{(xlen-12){o_instr.i.imm[11]}}, o_instr.i.imm};
            end
            opc_store: begin
                o_imm = {{(xlen-12){o_instr.s.imm_hi[6]}},
                         o_instr.s.imm_hi, o_instr.s.imm_lo};
            end
            opc_branch: begin
                o_imm = {{(xlen-13){o_instr.b.imm_12}},
                         o_instr.b.imm_12,
                         o_instr.b.imm_11,
                         o_instr.b.imm_10_5,
                         o_instr.b.imm_4_1,
                         1'b0};
            end
            default: begin
                o_imm = '0;
            end
        endcase
    end

endmodule

// File: source/control_unit.sv
`timescale 1ns/1ps

module control_unit
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     i_rst,
    input  instr_u   i_instr,
    input  logic     i_zero,
    input  logic     i_done,
    output logic     o_req,
    output logic     o_we,
    output logic     o_addr_sel,
    output logic     o_rf_we,
    output logic     o_rf_src,
    output logic     o_alu_src,
    output logic     o_pc_inc,
    output logic     o_pc_branch,
    output logic     o_ir_load,
    output alu_cmd_t o_alu_cmd,
    output logic     o_halt
);

    ctrl_state_t state;
    ctrl_state_t state_next;
    opcode_t     opcode;
    logic [2:0]  funct3;
    logic        sub_bit;
    logic        taken;
    alu_cmd_t    op_cmd;

    assign opcode  = i_instr.r.opcode;
    assign funct3  = i_instr.r.funct3;
    assign sub_bit = i_instr.r.funct7[5];

    // BNE takes the inverted zero flag
    assign taken = (funct3 == f3_bne) ? !i_zero : i_zero;

    assign o_halt = (state == st_halt);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state <= st_fetch;
        end else begin
            state <= state_next;
        end
    end

    // Funct7 only selects SUB for register ops
    always_comb begin
        case (funct3)
            f3_add_sub: op_cmd = (opcode == opc_op && sub_bit) ? alu_sub : alu_add;
            f3_xor:     op_cmd = alu_xor;
            f3_or:      op_cmd = alu_or;
            f3_and:     op_cmd = alu_and;
            f3_slt:     op_cmd = alu_slt;
            default:    op_cmd = alu_add;
        endcase
    end

    // ALU setup stays fixed for the whole instruction
    always_comb begin
        o_alu_src = 1'b1;
        o_alu_cmd = alu_add;
        case (opcode)
            opc_op: begin
                o_alu_src = 1'b0;
                o_alu_cmd = op_cmd;
            end
            opc_op_imm: begin
                o_alu_cmd = op_cmd;
            end
            opc_branch: begin
                o_alu_src = 1'b0;
                o_alu_cmd = alu_sub;
            end
            default: begin
                // Loads and stores add the offset to rs1
                o_alu_cmd = alu_add;
            end
        endcase
    end

    always_comb begin
        state_next  = state;
        o_req       = 1'b0;
        o_we        = 1'b0;
        o_addr_sel  = 1'b0;
        o_rf_we     = 1'b0;
        o_rf_src    = 1'b0;
        o_pc_inc    = 1'b0;
        o_pc_branch = 1'b0;
        o_ir_load   = 1'b0;
        case (state)
            st_fetch: begin
                o_req = 1'b1;
                if (i_done) begin
                    o_ir_load  = 1'b1;
                    state_next = st_decode;
                end
            end
            st_decode: begin
                state_next = (opcode == opc_system) ? st_halt : st_execute;
            end
            st_execute: begin
                if (opcode == opc_branch) begin
                    o_pc_branch = taken;
                    o_pc_inc    = !taken;
                    state_next  = st_fetch;
                end else if (opcode == opc_load || opcode == opc_store) begin
                    state_next = st_mem;
                end else begin
                    state_next = st_writeback;
                end
            end
            st_mem: begin
                o_req      = 1'b1;
                o_we       = (opcode == opc_store);
                o_addr_sel = 1'b1;
                if (i_done) begin
                    state_next = st_writeback;
                end
            end
            st_writeback: begin
                o_rf_we    = (opcode != opc_store);
                o_rf_src   = (opcode == opc_load);
                o_pc_inc   = 1'b1;
                state_next = st_fetch;
            end
            default: begin
                // Halted for good
                state_next = st_halt;
            end
        endcase
    end

endmodule

// File: source/datapath.sv
`timescale 1ns/1ps

module datapath
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;
#(
    parameter int addr_bits = 16
) (
    input  logic            clk,
    input  logic            i_rst,
    input  instr_u          i_instr,
    input  logic [xlen-1:0] i_imm,
    input  logic            i_addr_sel,
    input  logic            i_rf_we,
    input  logic            i_rf_src,
    input  logic            i_alu_src,
    input  logic            i_pc_inc,
    input  logic            i_pc_branch,
    input  alu_cmd_t        i_alu_cmd,
    input  logic [xlen-1:0] i_rdata,
    output logic            o_zero,
    output logic            o_pc_word_half,
    mem_req_if.core         mem
);

    logic [xlen-1:0] regs [1:31];
    logic [xlen-1:0] pc;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_res;
    logic [xlen-1:0] rf_din;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;

    assign rs1 = i_instr.r.rs1;
    assign rs2 = i_instr.r.rs2;
    assign rd  = i_instr.r.rd;

    // x0 is not stored
    assign rs1_val = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == 5'd0) ? '0 : regs[rs2];

    always_ff @(posedge clk) begin
        if (i_rf_we && rd != 5'd0) begin
            regs[rd] <= rf_din;
        end
    end

    // Operand and writeback muxes
    assign alu_b  = i_alu_src ? i_imm : rs2_val;
    assign rf_din = i_rf_src ? i_rdata : alu_res;

    // Program counter
    always_ff @(posedge clk) begin
        if (i_rst) begin
            pc <= '0;
        end else if (i_pc_branch) begin
            pc <= pc + i_imm;
        end else if (i_pc_inc) begin
            pc <= pc + xlen'(4);
        end
    end

    assign o_pc_word_half = pc[2];

    // Bus addresses count doublewords
    assign mem.addr  = i_addr_sel ? alu_res[addr_bits+2:3] : pc[addr_bits+2:3];
    assign mem.wdata = rs2_val;

    alu alu_i (
        .i_a   (rs1_val),
        .i_b   (alu_b),
        .i_cmd (i_alu_cmd),
        .o_res (alu_res),
        .o_zero(o_zero)
    );

endmodule

// File: source/wb_master.sv
`timescale 1ns/1ps

module wb_master
    import core_ctrl_pkg::*;
#(
    parameter int addr_bits = 16
) (
    input  logic                 clk,
    input  logic                 i_rst,
    mem_req_if.bus               mem,
    output logic                 o_wb_cyc,
    output logic                 o_wb_stb,
    output logic                 o_wb_we,
    output logic [addr_bits-1:0] o_wb_adr,
    output logic [xlen-1:0]      o_wb_dat,
    input  logic [xlen-1:0]      i_wb_dat,
    input  logic                 i_wb_ack
);

    localparam logic [1:0] wb_idle    = 2'd0;
    localparam logic [1:0] wb_active  = 2'd1;
    localparam logic [1:0] wb_recover = 2'd2;

    logic [1:0]      state;
    logic            done;
    logic [xlen-1:0] rdata;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state    <= wb_idle;
            o_wb_cyc <= 1'b0;
            o_wb_stb <= 1'b0;
            o_wb_we  <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                wb_idle: begin
                    if (mem.req) begin
                        state    <= wb_active;
                        o_wb_cyc <= 1'b1;
                        o_wb_stb <= 1'b1;
                        o_wb_we  <= mem.we;
                    end
                end
                wb_active: begin
                    if (i_wb_ack) begin
                        state    <= wb_recover;
                        o_wb_cyc <= 1'b0;
                        o_wb_stb <= 1'b0;
                        o_wb_we  <= 1'b0;
                        done     <= 1'b1;
                    end
                end
                default: begin
                    // Core still shows req while it sees done
                    state <= wb_idle;
                end
            endcase
        end
    end

    // Address and data held for the whole cycle
    always_ff @(posedge clk) begin
        if (state == wb_idle && mem.req) begin
            o_wb_adr <= mem.addr;
            o_wb_dat <= mem.wdata;
        end
        if (state == wb_active && i_wb_ack) begin
            rdata <= i_wb_dat;
        end
    end

    // Read data stays put until the next acknowledge
    assign mem.rdata = rdata;
    assign mem.done  = done;

endmodule

// File: source/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;
#(
    parameter int addr_bits = 16
) (
    input  logic                 clk,
    input  logic                 i_rst,
    output logic                 o_wb_cyc,
    output logic                 o_wb_stb,
    output logic                 o_wb_we,
    output logic [addr_bits-1:0] o_wb_adr,
    output logic [xlen-1:0]      o_wb_dat,
    input  logic [xlen-1:0]      i_wb_dat,
    input  logic                 i_wb_ack,
    output logic                 o_halt
);

    instr_u          instr;
    logic [xlen-1:0] imm;
    logic            pc_word_half;
    logic            zero;
    logic            req;
    logic            we;
    logic            addr_sel;
    logic            rf_we;
    logic            rf_src;
    logic            alu_src;
    logic            pc_inc;
    logic            pc_branch;
    logic            ir_load;
    alu_cmd_t        alu_cmd;

    mem_req_if #(.addr_bits(addr_bits)) mem_if ();

    // Request strobes come from the FSM
    assign mem_if.req = req;
    assign mem_if.we  = we;

    fetch_decode fetch_decode_i (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_fetch_done  (ir_load),
        .i_rdata       (mem_if.rdata),
        .i_pc_word_half(pc_word_half),
        .o_instr       (instr),
        .o_imm         (imm)
    );

    control_unit control_unit_i (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_instr    (instr),
        .i_zero     (zero),
        .i_done     (mem_if.done),
        .o_req      (req),
        .o_we       (we),
        .o_addr_sel (addr_sel),
        .o_rf_we    (rf_we),
        .o_rf_src   (rf_src),
        .o_alu_src  (alu_src),
        .o_pc_inc   (pc_inc),
        .o_pc_branch(pc_branch),
        .o_ir_load  (ir_load),
        .o_alu_cmd  (alu_cmd),
        .o_halt     (o_halt)
    );

    datapath #(.addr_bits(addr_bits)) datapath_i (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_instr       (instr),
        .i_imm         (imm),
        .i_addr_sel    (addr_sel),
        .i_rf_we       (rf_we),
        .i_rf_src      (rf_src),
        .i_alu_src     (alu_src),
        .i_pc_inc      (pc_inc),
        .i_pc_branch   (pc_branch),
        .i_alu_cmd     (alu_cmd),
        .i_rdata       (mem_if.rdata),
        .o_zero        (zero),
        .o_pc_word_half(pc_word_half),
        .mem           (mem_if.core)
    );

    wb_master #(.addr_bits(addr_bits)) wb_master_i (
        .clk     (clk),
        .i_rst   (i_rst),
        .mem     (mem_if.bus),
        .o_wb_cyc(o_wb_cyc),
        .o_wb_stb(o_wb_stb),
        .o_wb_we (o_wb_we),
        .o_wb_adr(o_wb_adr),
        .o_wb_dat(o_wb_dat),
        .i_wb_dat(i_wb_dat),
        .i_wb_ack(i_wb_ack)
    );

endmodule

// File: verification/rv_core_properties.sv
`timescale 1ns/1ps

module rv_core_properties
    import core_ctrl_pkg::*;
#(
    parameter int addr_bits = 16
) (
    input logic                 clk,
    input logic                 i_rst,
    input logic                 i_cyc,
    input logic                 i_stb,
    input logic                 i_we,
    input logic [addr_bits-1:0] i_adr,
    input logic [xlen-1:0]      i_dat,
    input logic                 i_ack
);

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (i_rst) i_stb |-> i_cyc)
        else $error("stb high outside a bus cycle");

    // Request held while the slave stalls
    a_hold_request: assert property (@(posedge clk) disable iff (i_rst)
        (i_stb && !i_ack) |=> ($stable(i_adr) && $stable(i_we) && $stable(i_dat)))
        else $error("bus request changed before acknowledge");

    a_idle_after_reset: assert property (@(posedge clk) i_rst |=> (!i_cyc && !i_stb))
        else $error("bus not idle after reset");

endmodule

bind wb_master rv_core_properties #(.addr_bits(addr_bits)) wb_props_i (
    .clk  (clk),
    .i_rst(i_rst),
    .i_cyc(o_wb_cyc),
    .i_stb(o_wb_stb),
    .i_we (o_wb_we),
    .i_adr(o_wb_adr),
    .i_dat(o_wb_dat),
    .i_ack(i_wb_ack)
);

// File: verification/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb
    import core_ctrl_pkg::*;
;

    localparam int          addr_bits   = 16;
    localparam int          halt_limit  = 5000;
    localparam int          idle_cycles = 20;
    localparam logic [31:0] lfsr_seed   = 32'd66720;

    logic                 clk;
    logic                 i_rst;
    logic                 o_wb_cyc;
    logic                 o_wb_stb;
    logic                 o_wb_we;
    logic [addr_bits-1:0] o_wb_adr;
    logic [xlen-1:0]      o_wb_dat;
    logic [xlen-1:0]      i_wb_dat;
    logic                 i_wb_ack;
    logic                 o_halt;

    logic [xlen-1:0]      mem [0:(1 << addr_bits)-1];
    logic [addr_bits-1:0] exp_addr [$];
    logic [xlen-1:0]      exp_data [$];
    int                   store_idx;
    logic [31:0]          lfsr;
    logic                 busy;
    logic [1:0]           wait_cnt;
    logic [1:0]           delay;

    rv_core_top #(.addr_bits(addr_bits)) rv_core_top_i (
        .clk     (clk),
        .i_rst   (i_rst),
        .o_wb_cyc(o_wb_cyc),
        .o_wb_stb(o_wb_stb),
        .o_wb_we (o_wb_we),
        .o_wb_adr(o_wb_adr),
        .o_wb_dat(o_wb_dat),
        .i_wb_dat(i_wb_dat),
        .i_wb_ack(i_wb_ack),
        .o_halt  (o_halt)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [xlen-1:0] got,
                               input logic [xlen-1:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    // Background pattern, so stray reads are easy to spot
    task automatic fill_memory();
        for (int a = 0; a < (1 << addr_bits); a++) begin
            mem[a] = {16'hbad0, 16'(a), 16'(~a), 16'(a)};
        end
    endtask

    task automatic load_stimulus();
        int          fd;
        int          n;
        string       line;
        byte         tag;
        logic [31:0] a;
        logic [63:0] d;
        fd = $fopen("verification/core_stimulus.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open the stimulus file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 1) begin
                    tag = line.getc(0);
                    if (tag == "M" || tag == "S") begin
                        n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, d);
                        if (n != 2) begin
                            report_failure("malformed line in the stimulus file");
                        end else if (tag == "M") begin
                            mem[a[addr_bits-1:0]] = d;
                        end else begin
                            exp_addr.push_back(a[addr_bits-1:0]);
                            exp_data.push_back(d);
                        end
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic record_store(input logic [addr_bits-1:0] adr, input logic [xlen-1:0] dat);
        if (store_idx >= exp_addr.size()) begin
            report_failure("a store happened after the last expected one");
        end else begin
            check_value("o_wb_adr", xlen'(adr), xlen'(exp_addr[store_idx]));
            check_value("o_wb_dat", dat, exp_data[store_idx]);
            store_idx = store_idx + 1;
        end
    endtask

    task automatic respond();
        i_wb_ack <= 1'b1;
        i_wb_dat <= mem[o_wb_adr];
        if (o_wb_we) begin
            mem[o_wb_adr] = o_wb_dat;
            record_store(o_wb_adr, o_wb_dat);
        end
    endtask

    // Wishbone slave with 0 to 3 wait cycles per transfer
    always @(posedge clk) begin
        if (i_rst) begin
            i_wb_ack <= 1'b0;
            busy     <= 1'b0;
            wait_cnt <= 2'd0;
        end else if (i_wb_ack) begin
            i_wb_ack <= 1'b0;
            busy     <= 1'b0;
        end else if (o_wb_cyc && o_wb_stb) begin
            if (!busy) begin
                lfsr = lfsr_next(lfsr);
                delay[0] = lfsr[0];
                lfsr = lfsr_next(lfsr);
                delay[1] = lfsr[0];
                if (delay == 2'd0) begin
                    respond();
                end else begin
                    busy     <= 1'b1;
                    wait_cnt <= delay - 2'd1;
                end
            end else if (wait_cnt == 2'd0) begin
                respond();
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

    initial begin
        int cycles;
        i_rst     <= 1'b1;
        i_wb_ack  <= 1'b0;
        i_wb_dat  <= '0;
        busy      <= 1'b0;
        wait_cnt  <= 2'd0;
        delay     = 2'd0;
        lfsr      = lfsr_seed;
        store_idx = 0;
        fill_memory();
        load_stimulus();
        repeat (2) @(posedge clk);
        i_rst <= 1'b0;

        cycles = 0;
        while (!o_halt && cycles < halt_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!o_halt) begin
            report_failure("the core did not halt within the cycle limit");
        end else begin
            // Halted core must leave the bus alone
            cycles = 0;
            while (cycles < idle_cycles) begin
                @(negedge clk);
                if (o_wb_cyc || o_wb_stb) begin
                    report_failure("a bus cycle started after halt");
                end else if (!o_halt) begin
                    report_failure("the halt output dropped");
                end
                cycles++;
            end
            if (store_idx != exp_addr.size()) begin
                $display("only %0d of %0d expected stores were seen",
                         store_idx, exp_addr.size());
                $display("** FAIL **");
                $fatal(1);
            end else begin
                $display("** PASS **");
                $finish;
            end
        end
    end

endmodule

// File: verification/core_stimulus.txt
# M <dword address> <data>: memory image, two instructions per dword, low half first
# S <dword address> <data>: expected stores in order
M 0000 FF90011306400093
M 0001 002081B340000513
M 0002 4011023300353023
M 0003 0020F2B300453423
M 0004 0020E33300553823
M 0005 0020C3B300653C23
M 0006 0011243302753023
M 0007 028534230020A4B3
M 0008 0010803302953823
M 0009 FF01759302053C23
M 000A 04B5302380006613
M 000B 1005069304C53423
M 000C 60000793FE16BC23
M 000D 04E538230087B703
M 000E 04153C2300208463
M 000F 0625302300209463
M 0010 0625302300108463
M 0011 0615302300109463
M 0012 0050091300000893
M 0013 FF289EE300188893
M 0014 0010007307153423
M 00C0 FEDCBA9876543210
M 00C1 0123456789ABCDEF
S 0080 000000000000005D
S 0081 FFFFFFFFFFFFFF95
S 0082 0000000000000060
S 0083 FFFFFFFFFFFFFFFD
S 0084 FFFFFFFFFFFFFF9D
S 0085 0000000000000001
S 0086 0000000000000000
S 0087 0000000000000000
S 0088 FFFFFFFFFFFFFFF0
S 0089 FFFFFFFFFFFFF800
S 009F 0000000000000064
S 008A 0123456789ABCDEF
S 008B 0000000000000064
S 008C 0000000000000064
S 008D 0000000000000005

// File: rv_core.f
source/riscv_isa_pkg.sv
source/core_ctrl_pkg.sv
source/mem_req_if.sv
source/alu.sv
source/fetch_decode.sv
source/control_unit.sv
source/datapath.sv
source/wb_master.sv
source/rv_core_top.sv
verification/rv_core_properties.sv
verification/rv_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the rv_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f rv_core.f --top-module rv_core_tb \
        -o sim_rv_core; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/sim_rv_core > sim.log 2>&1; then
    echo "Simulation exited with an error"
fi

if grep -qx '\*\* PASS \*\*' sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
